// File: files.f
+incdir+tb
logic/fu_pkg.sv
logic/fu_dispatch.sv
logic/alu_unit.sv
logic/mult_pipe.sv
logic/result_arbiter.sv
logic/fu_cluster.sv
tb/fu_cluster_tb.sv

// File: logic/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit
  import fu_pkg::*;
(
  input  wire         clock,
  input  wire         reset,

  // Op from dispatch
  input  wire         in_valid,
  input  fu_issue_t   in_op,
  output logic        in_ready,

  // Result towards the arbiter
  output logic        out_valid,
  output fu_result_t  out_result,
  input  wire         out_ready
);

  logic [XLEN-1:0]    opa;
  logic [XLEN-1:0]    opb;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    alu_res;
  logic               br_taken;

  assign opa   = in_op.t1_value;
  assign opb   = in_op.t2_value;
  assign shamt = opb[SHAMT_W-1:0];

  // Two's complement a < b built on the unsigned compare
  function automatic logic signed_lt(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    if (a[XLEN-1] == b[XLEN-1]) begin
      return a < b;              // Same sign, unsigned order holds
    end
    return a[XLEN-1];            // Mixed signs, the negative one is smaller
  endfunction

  // Branch condition on t1_value
  always_comb begin
    case (in_op.br_func[1:0])
      2'b00:   br_taken = !opa[0];                                // LBC
      2'b01:   br_taken = (opa == '0);                            // EQ
      2'b10:   br_taken = opa[XLEN-1];                            // LT
      default: br_taken = opa[XLEN-1] || (opa == '0);             // LE
    endcase
    if (in_op.br_func[2]) begin
      br_taken = !br_taken;      // LBS, NE, GE, GT
    end
  end

  // Result mux
  always_comb begin
    case (in_op.func)
      ALU_ADDQ:   alu_res = opa + opb;
      ALU_SUBQ:   alu_res = opa - opb;
      ALU_AND:    alu_res = opa & opb;
      ALU_BIC:    alu_res = opa & ~opb;
      ALU_BIS:    alu_res = opa | opb;
      ALU_ORNOT:  alu_res = opa | ~opb;
      ALU_XOR:    alu_res = opa ^ opb;
      ALU_EQV:    alu_res = opa ^ ~opb;
      ALU_SRL:    alu_res = opa >> shamt;
      ALU_SLL:    alu_res = opa << shamt;
      ALU_SRA:    alu_res = $signed(opa) >>> shamt;              // Sign fill
      ALU_CMPULT: alu_res = {{(XLEN-1){1'b0}}, (opa < opb)};
      ALU_CMPEQ:  alu_res = {{(XLEN-1){1'b0}}, (opa == opb)};
      ALU_CMPULE: alu_res = {{(XLEN-1){1'b0}}, (opa <= opb)};
      ALU_CMPLT:  alu_res = {{(XLEN-1){1'b0}}, signed_lt(opa, opb)};
      ALU_CMPLE:  alu_res = {{(XLEN-1){1'b0}}, (signed_lt(opa, opb) || (opa == opb))};
      BR_COND:    alu_res = {{(XLEN-1){1'b0}}, br_taken};
      default:    alu_res = UNDEF_RESULT;                        // MULQ never routed here
    endcase
  end

  // Output register accepts when empty or being drained
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      out_result.result   <= alu_res;
      out_result.dest_tag <= in_op.dest_tag;
    end
  end

  // Result waiting on the arbiter stays put
  a_out_hold: assert property (
    @(posedge clock) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
  ) else $error("alu_unit: stalled result changed");

endmodule

`default_nettype wire

// File: logic/fu_cluster.sv
`timescale 1ns/100ps
`default_nettype none

module fu_cluster
  import fu_pkg::*;
(
  input  wire         clock,
  input  wire         reset,

  input  wire         issue_valid,
  input  fu_issue_t   issue_packet,
  output logic        issue_ready,

  output logic        out_valid,
  output fu_result_t  out_result,
  input  wire         out_ready
);

  // Dispatch to units
  logic       alu_in_valid,  alu_in_ready;
  logic       mult_in_valid, mult_in_ready;
  fu_issue_t  alu_in_op;
  fu_issue_t  mult_in_op;

  // Units to arbiter
  logic       alu_res_valid,  alu_res_ready;
  logic       mult_res_valid, mult_res_ready;
  fu_result_t alu_res;
  fu_result_t mult_res;

  fu_dispatch dispatch_i (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_packet (issue_packet),
    .issue_ready  (issue_ready),
    .alu_valid    (alu_in_valid),
    .alu_op       (alu_in_op),
    .alu_ready    (alu_in_ready),
    .mult_valid   (mult_in_valid),
    .mult_op      (mult_in_op),
    .mult_ready   (mult_in_ready)
  );

  alu_unit alu_i (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (alu_in_valid),
    .in_op      (alu_in_op),
    .in_ready   (alu_in_ready),
    .out_valid  (alu_res_valid),
    .out_result (alu_res),
    .out_ready  (alu_res_ready)
  );

  mult_pipe mult_i (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (mult_in_valid),
    .in_op      (mult_in_op),
    .in_ready   (mult_in_ready),
    .out_valid  (mult_res_valid),
    .out_result (mult_res),
    .out_ready  (mult_res_ready)
  );

  result_arbiter arbiter_i (
    .clock       (clock),
    .reset       (reset),
    .alu_valid   (alu_res_valid),
    .alu_result  (alu_res),
    .alu_ready   (alu_res_ready),
    .mult_valid  (mult_res_valid),
    .mult_result (mult_res),
    .mult_ready  (mult_res_ready),
    .out_valid   (out_valid),
    .out_result  (out_result),
    .out_ready   (out_ready)
  );

endmodule

`default_nettype wire

// File: logic/fu_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module fu_dispatch
  import fu_pkg::*;
(
  input  wire        clock,
  input  wire        reset,

  // From the reservation stations
  input  wire        issue_valid,
  input  fu_issue_t  issue_packet,
  output logic       issue_ready,

  // To the ALU
  output logic       alu_valid,
  output fu_issue_t  alu_op,
  input  wire        alu_ready,

  // To the multiplier
  output logic       mult_valid,
  output fu_issue_t  mult_op,
  input  wire        mult_ready
);

  logic       full_q;                   // Issue register holds an op
  logic       to_mult_q;                // Route decoded at capture
  fu_issue_t  op_q;
  logic       op_leaves;                // Held op taken by its unit this cycle

  // Steer the held op to exactly one unit
  assign alu_valid  = full_q && !to_mult_q;
  assign mult_valid = full_q &&  to_mult_q;
  assign alu_op     = op_q;
  assign mult_op    = op_q;

  assign op_leaves   = (alu_valid && alu_ready) || (mult_valid && mult_ready);
  assign issue_ready = !full_q || op_leaves;    // Empty or draining this cycle

  // Occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (issue_ready) begin
      full_q <= issue_valid;
    end
  end

  // Payload and route
  always_ff @(posedge clock) begin
    if (issue_valid && issue_ready) begin
      op_q      <= issue_packet;
      to_mult_q <= (issue_packet.func == ALU_MULQ);   // Everything else incl. unused codes to ALU
    end
  end

  // A stalled op must not change under the unit that is waiting for it
  a_held_op_stable: assert property (
    @(posedge clock) disable iff (reset)
    (full_q && !op_leaves) |=> (full_q && $stable(op_q) && $stable(to_mult_q))
  ) else $error("fu_dispatch: held op changed while its unit was not ready");

endmodule

`default_nettype wire

// File: logic/fu_pkg.sv
`default_nettype none

package fu_pkg;

  // Architectural widths
  localparam int XLEN        = 64;
  localparam int TAG_W       = 6;                 // Destination tag, 64 physical regs
  localparam int SHAMT_W     = 6;                 // Shift amount from t2_value[5:0]

  // Multiplier geometry
  localparam int MULT_STAGES = 4;
  localparam int SLICE_W     = XLEN / MULT_STAGES; // One 16-bit slice of t2 per stage

  // Returned for encodings the ALU does not implement
  localparam logic [XLEN-1:0] UNDEF_RESULT = 64'hdead_beef_baad_beef;

  // Function codes carried by an issued micro-op
  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'd0,
    ALU_SUBQ   = 5'd1,
    ALU_AND    = 5'd2,
    ALU_BIC    = 5'd3,                            // a & ~b
    ALU_BIS    = 5'd4,                            // a | b
    ALU_ORNOT  = 5'd5,
    ALU_XOR    = 5'd6,
    ALU_EQV    = 5'd7,                            // a ^ ~b
    ALU_SRL    = 5'd8,
    ALU_SLL    = 5'd9,
    ALU_SRA    = 5'd10,
    ALU_CMPULT = 5'd11,
    ALU_CMPEQ  = 5'd12,
    ALU_CMPULE = 5'd13,
    ALU_CMPLT  = 5'd14,
    ALU_CMPLE  = 5'd15,
    ALU_MULQ   = 5'd16,                           // Only code routed to the multiplier
    BR_COND    = 5'd17
  } fu_func_e;

  // Branch conditions; bit 2 negates the base test in bits 1:0
  typedef enum logic [2:0] {
    BR_LBC = 3'd0,                                // Low bit clear
    BR_EQ  = 3'd1,
    BR_LT  = 3'd2,
    BR_LE  = 3'd3,
    BR_LBS = 3'd4,                                // Low bit set
    BR_NE  = 3'd5,
    BR_GE  = 3'd6,
    BR_GT  = 3'd7
  } br_cond_e;

  // One micro-op from the reservation stations
  typedef struct packed {
    fu_func_e          func;
    br_cond_e          br_func;                   // Only meaningful for BR_COND
    logic [XLEN-1:0]   t1_value;
    logic [XLEN-1:0]   t2_value;
    logic [TAG_W-1:0]  dest_tag;
  } fu_issue_t;

  // One completed result for the common data bus
  typedef struct packed {
    logic [XLEN-1:0]   result;
    logic [TAG_W-1:0]  dest_tag;
  } fu_result_t;

endpackage

`default_nettype wire

// File: logic/mult_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module mult_pipe
  import fu_pkg::*;
(
  input  wire         clock,
  input  wire         reset,

  // Op from dispatch
  input  wire         in_valid,
  input  fu_issue_t   in_op,
  output logic        in_ready,

  // Product towards the arbiter
  output logic        out_valid,
  output fu_result_t  out_result,
  input  wire         out_ready
);

  localparam int LAST = MULT_STAGES - 1;

  logic [MULT_STAGES-1:0] stg_valid;
  logic [MULT_STAGES-1:0] stg_ready;        // Stage can take new contents this cycle
  logic [XLEN-1:0]        stg_sum [MULT_STAGES];   // Running low 64 bits of the product
  logic [TAG_W-1:0]       stg_tag [MULT_STAGES];
  logic [XLEN-1:0]        stg_a   [LAST];          // Operands only needed up to stage 2
  logic [XLEN-1:0]        stg_b   [LAST];

  // Multiplicand times one slice of the multiplier, aligned to its weight
  function automatic logic [XLEN-1:0] slice_pp(input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b,
                                               input int unsigned     idx);
    logic [SLICE_W-1:0] slice;
    slice = b[idx*SLICE_W +: SLICE_W];
    return (a * {{(XLEN-SLICE_W){1'b0}}, slice}) << (idx * SLICE_W);
  endfunction

  // Ready ripples back from the arbiter
  always_comb begin
    stg_ready[LAST] = !stg_valid[LAST] || out_ready;
    for (int i = LAST - 1; i >= 0; i--) begin
      stg_ready[i] = !stg_valid[i] || stg_ready[i+1];
    end
  end

  assign in_ready   = stg_ready[0];
  assign out_valid  = stg_valid[LAST];
  assign out_result = '{result: stg_sum[LAST], dest_tag: stg_tag[LAST]};

  // Valid bits, one per stage
  always_ff @(posedge clock) begin
    if (reset) begin
      stg_valid <= '0;
    end else begin
      if (stg_ready[0]) stg_valid[0] <= in_valid;
      for (int i = 1; i < MULT_STAGES; i++) begin
        if (stg_ready[i]) begin
          stg_valid[i] <= stg_valid[i-1];   // Bubble moves along too
        end
      end
    end
  end

  // First stage, slice 0
  always_ff @(posedge clock) begin
    if (in_valid && stg_ready[0]) begin
      stg_sum[0] <= slice_pp(in_op.t1_value, in_op.t2_value, 0);
      stg_tag[0] <= in_op.dest_tag;
      stg_a[0]   <= in_op.t1_value;
      stg_b[0]   <= in_op.t2_value;
    end
  end

  for (genvar s = 1; s < MULT_STAGES; s++) begin : g_stage
    always_ff @(posedge clock) begin
      if (stg_valid[s-1] && stg_ready[s]) begin
        stg_sum[s] <= stg_sum[s-1] + slice_pp(stg_a[s-1], stg_b[s-1], s);
        stg_tag[s] <= stg_tag[s-1];
      end
    end

    // Operands forwarded while slices remain
    if (s < LAST) begin : g_fwd
      always_ff @(posedge clock) begin
        if (stg_valid[s-1] && stg_ready[s]) begin
          stg_a[s] <= stg_a[s-1];
          stg_b[s] <= stg_b[s-1];
        end
      end
    end
  end

  // No product is lost or altered while its stage is blocked
  for (genvar s = 0; s < MULT_STAGES; s++) begin : g_chk
    a_stall_hold: assert property (
      @(posedge clock) disable iff (reset)
      (stg_valid[s] && !stg_ready[s]) |=>
        (stg_valid[s] && $stable(stg_tag[s]) && $stable(stg_sum[s]))
    ) else $error("mult_pipe: stage %0d overwritten while stalled", s);
  end

endmodule

`default_nettype wire

// File: logic/result_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module result_arbiter
  import fu_pkg::*;
(
  input  wire         clock,
  input  wire         reset,

  // ALU source
  input  wire         alu_valid,
  input  fu_result_t  alu_result,
  output logic        alu_ready,

  // Multiplier source, older op so it goes first
  input  wire         mult_valid,
  input  fu_result_t  mult_result,
  output logic        mult_ready,

  // Common data bus
  output logic        out_valid,
  output fu_result_t  out_result,
  input  wire         out_ready
);

  logic can_load;               // Bus register empty or draining
  logic alu_grant;
  logic mult_grant;

  assign can_load   = !out_valid || out_ready;
  assign mult_ready = can_load;
  assign alu_ready  = can_load && !mult_valid;   // Loses to a waiting product

  assign mult_grant = mult_valid && mult_ready;
  assign alu_grant  = alu_valid && alu_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (can_load) begin
      out_valid <= mult_grant || alu_grant;
    end
  end

  // Payload follows the grant
  always_ff @(posedge clock) begin
    if (mult_grant) begin
      out_result <= mult_result;
    end else if (alu_grant) begin
      out_result <= alu_result;
    end
  end

  a_one_grant: assert property (
    @(posedge clock) disable iff (reset)
    !(alu_grant && mult_grant)
  ) else $error("result_arbiter: both sources granted");

  // Bus holds its value until the consumer takes it
  a_bus_hold: assert property (
    @(posedge clock) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
  ) else $error("result_arbiter: out_result changed under back-pressure");

endmodule

`default_nettype wire

// File: tb/fu_ref_model.svh
`ifndef FU_REF_MODEL_SVH
`define FU_REF_MODEL_SVH

// Branch outcome read straight off the condition table
function automatic logic ref_branch(input br_cond_e cond, input logic [XLEN-1:0] v);
  case (cond)
    BR_LBC:  return !v[0];
    BR_EQ:   return v == '0;
    BR_LT:   return $signed(v) < 0;
    BR_LE:   return $signed(v) <= 0;
    BR_LBS:  return v[0];
    BR_NE:   return v != '0;
    BR_GE:   return $signed(v) >= 0;
    default: return $signed(v) > 0;              // BR_GT
  endcase
endfunction

// Expected bus value for any micro-op
function automatic logic [XLEN-1:0] ref_result(input fu_issue_t op);
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  int unsigned     sh;
  a  = op.t1_value;
  b  = op.t2_value;
  sh = b[5:0];                                   // Shift amount, low six bits only
  case (op.func)
    ALU_ADDQ:   return a + b;
    ALU_SUBQ:   return a - b;
    ALU_AND:    return a & b;
    ALU_BIC:    return a & ~b;
    ALU_BIS:    return a | b;
    ALU_ORNOT:  return a | ~b;
    ALU_XOR:    return a ^ b;
    ALU_EQV:    return ~(a ^ b);
    ALU_SRL:    return a >> sh;
    ALU_SLL:    return a << sh;
    // Logical shift, then fill the vacated top bits with the sign
    ALU_SRA:    return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
    ALU_CMPULT: return (a < b) ? 1 : 0;
    ALU_CMPEQ:  return (a == b) ? 1 : 0;
    ALU_CMPULE: return (a <= b) ? 1 : 0;
    ALU_CMPLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
    ALU_CMPLE:  return ($signed(a) <= $signed(b)) ? 1 : 0;
    ALU_MULQ:   return a * b;                    // Low half of the product
    BR_COND:    return ref_branch(op.br_func, a) ? 1 : 0;
    default:    return UNDEF_RESULT;
  endcase
endfunction

`endif

// File: tb/fu_cluster_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fu_cluster_tb
  import fu_pkg::*;
();

  localparam int WAIT_LIMIT = 64;                         // Cycles per wait loop
  localparam logic [XLEN-1:0] LFSR_TAPS = 64'hd800_0000_0000_0000;

  logic       clock;
  logic       reset;
  logic       issue_valid;
  fu_issue_t  issue_packet;
  logic       issue_ready;
  logic       out_valid;
  fu_result_t out_result;
  logic       out_ready;

  logic [XLEN-1:0]  lfsr_state;
  logic [TAG_W-1:0] next_tag;
  int               cycle_cnt;
  int               issued_cycle;                         // Counter value just after a transfer
  fu_issue_t        op_by_tag   [2**TAG_W];
  bit               tag_pending [2**TAG_W];

  fu_cluster dut_i (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_packet (issue_packet),
    .issue_ready  (issue_ready),
    .out_valid    (out_valid),
    .out_result   (out_result),
    .out_ready    (out_ready)
  );

  `include "fu_ref_model.svh"

  always #20 clock = ~clock;                              // 40 ns period
  always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

  task automatic stop_with_failure();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // Galois form shifts right and folds the taps in when a one drops out
  function automatic logic [XLEN-1:0] lfsr_step(input logic [XLEN-1:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[XLEN-2:0], lfsr_state[0]};          // One step per bit
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // Fresh tag per op kept for out-of-order lookup
  function automatic fu_issue_t make_op(input fu_func_e f, input br_cond_e c,
                                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    fu_issue_t op;
    op.func     = f;
    op.br_func  = c;
    op.t1_value = a;
    op.t2_value = b;
    op.dest_tag = next_tag;
    next_tag    = next_tag + 1'b1;
    op_by_tag[op.dest_tag] = op;
    return op;
  endfunction

  // Called at a falling edge and returns at the falling edge after the transfer
  task automatic issue_op(input fu_issue_t op);
    logic taken;
    taken        = 1'b0;
    issue_valid  = 1'b1;
    issue_packet = op;
    for (int t = 0; t < WAIT_LIMIT && !taken; t++) begin
      #1;                                                 // Let ready settle after driving
      if (issue_ready) taken = 1'b1;
      else @(negedge clock);
    end
    if (!taken) begin
      $display("Timeout: issue_ready never rose for tag %0d", op.dest_tag);
      stop_with_failure();
    end
    @(posedge clock);                                     // Transfer edge
    @(negedge clock);
    issued_cycle = cycle_cnt;
  endtask

  task automatic wait_result(output fu_result_t r, output int at_cycle);
    logic seen;
    seen = 1'b0;
    for (int t = 0; t < WAIT_LIMIT && !seen; t++) begin
      if (out_valid) seen = 1'b1;
      else @(negedge clock);
    end
    if (!seen) begin
      $display("Timeout: no result appeared on the result bus");
      stop_with_failure();
    end
    r        = out_result;
    at_cycle = cycle_cnt;
    if (out_ready) begin
      @(posedge clock);                                   // Consumed here
      @(negedge clock);
    end
  endtask

  // Lone op through an idle cluster with the transfer edge counted in the latency
  task automatic run_single(input fu_issue_t op, input int exp_latency);
    fu_result_t r;
    int         at;
    issue_op(op);
    issue_valid = 1'b0;
    wait_result(r, at);
    check("latency", at - issued_cycle + 1, exp_latency);
    check("out_result.dest_tag", r.dest_tag, op.dest_tag);
    check("out_result.result", r.result, ref_result(op));
  endtask

  task automatic idle_after_reset();
    check("out_valid", out_valid, 0);
    check("issue_ready", issue_ready, 1);
  endtask

  task automatic alu_op_sweep();
    logic [XLEN-1:0] corner_a [3];
    logic [XLEN-1:0] corner_b [5];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    corner_a = '{64'd0, {XLEN{1'b1}}, 64'h8000_0000_0000_0000};
    corner_b = '{64'd0, 64'd1, 64'd63, {XLEN{1'b1}}, 64'h8000_0000_0000_0000};
    for (int f = 0; f < 16; f++) begin                    // ADDQ through CMPLE
      for (int i = 0; i < 3; i++)
        for (int j = 0; j < 5; j++)
          run_single(make_op(fu_func_e'(f), BR_LBC, corner_a[i], corner_b[j]), 3);
      repeat (4) begin
        a = rand_bits(XLEN);
        b = rand_bits(XLEN);
        run_single(make_op(fu_func_e'(f), BR_LBC, a, b), 3);
      end
    end
    run_single(make_op(fu_func_e'(25), BR_LBC, 64'd5, 64'd7), 3);   // Unused encoding
  endtask

  task automatic branch_cond_sweep();
    logic [XLEN-1:0] vals [5];
    vals = '{64'd0, 64'hffff_ffff_ffff_fffe, 64'hffff_ffff_ffff_fffd, 64'd8, 64'd19};
    for (int c = 0; c < 8; c++)
      for (int v = 0; v < 5; v++)
        run_single(make_op(BR_COND, br_cond_e'(c), vals[v], 64'd0), 3);
  endtask

  task automatic single_mul_latency();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    repeat (3) begin
      a = rand_bits(XLEN);
      b = rand_bits(XLEN);
      run_single(make_op(ALU_MULQ, BR_LBC, a, b), 6);
    end
  endtask

  task automatic mul_back_to_back();
    fu_issue_t       ops [4];
    fu_result_t      r;
    int              at;
    int              prev_at;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < 4; i++) begin
      a      = rand_bits(XLEN);
      b      = rand_bits(XLEN);
      ops[i] = make_op(ALU_MULQ, BR_LBC, a, b);
    end
    for (int i = 0; i < 4; i++) issue_op(ops[i]);         // One per cycle
    issue_valid = 1'b0;
    prev_at     = 0;
    for (int i = 0; i < 4; i++) begin
      wait_result(r, at);
      check("out_result.dest_tag", r.dest_tag, ops[i].dest_tag);
      check("out_result.result", r.result, ref_result(ops[i]));
      if (i > 0) check("result spacing", at - prev_at, 1);
      prev_at = at;
    end
  endtask

  task automatic stalled_burst();
    fu_issue_t       ops [12];
    fu_result_t      held;
    fu_result_t      r;
    int              at;
    int              k;
    logic            stalled;
    logic [1:0]      kind;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < 12; i++) begin
      kind = rand_bits(2);
      a    = rand_bits(XLEN);
      b    = rand_bits(XLEN);
      case (kind)
        2'd2:    ops[i] = make_op(BR_COND, br_cond_e'(rand_bits(3)), a, b);
        2'd3:    ops[i] = make_op(ALU_MULQ, BR_LBC, a, b);
        default: ops[i] = make_op(fu_func_e'(rand_bits(4)), BR_LBC, a, b);
      endcase
      tag_pending[ops[i].dest_tag] = 1'b1;
    end
    out_ready = 1'b0;                                     // Bus blocked
    k         = 0;
    stalled   = 1'b0;
    while (k < 12 && !stalled) begin
      issue_valid  = 1'b1;
      issue_packet = ops[k];
      #1;
      if (!issue_ready) stalled = 1'b1;                   // Op k stays offered
      else begin
        @(posedge clock);
        @(negedge clock);
        k++;
      end
    end
    if (!stalled) begin
      $display("issue_ready stayed high for the whole burst with out_ready low");
      stop_with_failure();
    end
    for (int t = 0; t < WAIT_LIMIT && !out_valid; t++) @(negedge clock);
    if (!out_valid) begin
      $display("Timeout: out_valid never rose while the bus was blocked");
      stop_with_failure();
    end
    held = out_result;
    repeat (4) begin
      @(negedge clock);
      check("out_valid", out_valid, 1);
      check("out_result.result", out_result.result, held.result);
      check("out_result.dest_tag", out_result.dest_tag, held.dest_tag);
      check("issue_ready", issue_ready, 0);
    end
    fork
      begin                                               // Rest of the burst
        for (int j = k; j < 12; j++) issue_op(ops[j]);
        issue_valid = 1'b0;
      end
      begin                                               // Release and drain
        out_ready = 1'b1;
        for (int n = 0; n < 12; n++) begin
          wait_result(r, at);
          if (!tag_pending[r.dest_tag]) begin
            $display("Tag %0d returned twice or was never issued", r.dest_tag);
            stop_with_failure();
          end
          tag_pending[r.dest_tag] = 1'b0;
          check("out_result.result", r.result, ref_result(op_by_tag[r.dest_tag]));
        end
      end
    join
    repeat (3) begin
      @(negedge clock);
      check("out_valid", out_valid, 0);                   // Nothing extra on the bus
    end
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    issue_valid  = 1'b0;
    issue_packet = '0;
    out_ready    = 1'b1;
    lfsr_state   = 64'd46;
    next_tag     = '0;
    cycle_cnt    = 0;
    issued_cycle = 0;
    foreach (tag_pending[i]) tag_pending[i] = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    idle_after_reset();
    alu_op_sweep();
    branch_cond_sweep();
    single_mul_latency();
    mul_back_to_back();
    stalled_burst();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
